// File: src.f
hdl/pingPongPkg.sv
hdl/lineWriter.sv
hdl/readEngine.sv
hdl/rspChecker.sv
hdl/swPingPongTop.sv
test/pingPongAssertions.sv
test/pingPongTb.sv

// File: run.sh
#!/usr/bin/env bash
# builds the ping-pong testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module pingPongTb \
   -o pingPongSim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/pingPongSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
   echo "simulation exited with status $simStatus"
   exit 1
fi

if grep -qx "NO ERRORS" sim.log; then
   exit 0
fi
echo "pass line not found in sim.log"
exit 1

// File: test/pingPongTb.sv
// directed testbench for swPingPongTop
// the host model accepts requests with random stalls, keeps the written lines
// and answers reads after a random delay, possibly out of order
// each test resets the DUT, runs one exchange and checks the request logs

module pingPongTb
   import pingPongPkg::*;
();

   logic                      Clk_400 = 1'b0;
   logic                      rstN = 1'b0;
   logic                      go = 1'b0;
   logic [numLinesWidth-1:0]  numLines = '0;
   logic [cfgWidth-1:0]       testCfg = '0;
   logic                      csrWrite = 1'b0;
   logic [addrWidth-1:0]      wrAddr;
   logic [lineWidth-1:0]      wrData;
   logic                      wrEn;
   logic                      wrFence;
   logic                      wrSent = 1'b0;
   logic [addrWidth-1:0]      rdAddr;
   logic                      rdEn;
   logic                      rdSent = 1'b0;
   logic                      rdRspValid = 1'b0;
   logic [addrWidth-1:0]      rdRspAddr = '0;
   logic [lineWidth-1:0]      rdData = '0;
   logic                      testCmp;
   logic                      errorValid;
   logic [errorInfoWidth-1:0] errorInfo;

   swPingPongTop i_dut (.*);

   always #20 Clk_400 = ~Clk_400;   // period 40

   // ******************************
   // host memory model
   // ******************************
   logic [31:0]          rngState = 32'h417c_6bb0;
   logic [lineWidth-1:0] wrMem [16];    // lines as written
   logic [lineWidth-1:0] rdMem [16];    // copy served to reads
   logic [addrWidth-1:0] pendAddr[$];   // reads in flight
   logic [lineWidth-1:0] pendData[$];
   int                   pendDelay[$];
   int                   wrLog[$];      // write addresses, -1 marks a fence
   int                   rdLog[$];      // read addresses in issue order
   int                   sentPct;       // chance of a sent strobe, percent
   int                   missLeft;      // poll answers still withheld
   int                   corruptAddr;   // line spoiled in the copy
   int                   rspNum;
   int                   corruptPos;    // response number of the spoiled line
   logic                 flagSeen;

   function automatic logic [31:0] nextRand();
      logic [31:0] x;
      x = rngState;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rngState = x;
      return x;
   endfunction

   always @(negedge Clk_400)
   begin : hostModel
      int hit;
      if (!rstN)
      begin
         for (int i = 0; i < 16; i++)
            wrMem[i] = {16{~32'(i)}};   // low bits never equal the address
         pendAddr.delete();
         pendData.delete();
         pendDelay.delete();
         wrLog.delete();
         rdLog.delete();
         rspNum     = 0;
         flagSeen   = 1'b0;
         wrSent     = 1'b0;
         rdSent     = 1'b0;
         rdRspValid = 1'b0;
      end
      else
      begin
         // responses first, the oldest ready one wins
         hit = -1;
         foreach (pendDelay[i])
         begin
            pendDelay[i]--;
            if (pendDelay[i] <= 0 && hit < 0)
               hit = i;
         end
         rdRspValid = (hit >= 0);
         if (hit >= 0)
         begin
            rdRspAddr = pendAddr[hit];
            rdData    = pendData[hit];
            rspNum++;
            if (int'(rdRspAddr) == corruptAddr)
               corruptPos = rspNum;
            pendAddr.delete(hit);
            pendData.delete(hit);
            pendDelay.delete(hit);
         end
         // request seen now is taken at the next rising edge
         wrSent = (wrEn || wrFence) && ((nextRand() % 32'd100) < 32'(sentPct));
         if (wrSent && wrFence)
            wrLog.push_back(-1);
         else if (wrSent)
         begin
            wrLog.push_back(int'(wrAddr));
            wrMem[wrAddr[3:0]] = wrData;
            if (wrData == flagLine)
            begin
               rdMem = wrMem;   // flag seen, publish the lines
               if (corruptAddr >= 0)
                  rdMem[corruptAddr][15:0] = rdMem[corruptAddr][15:0] ^ 16'h00ff;
               flagSeen = 1'b1;
            end
         end
         rdSent = rdEn && ((nextRand() % 32'd100) < 32'(sentPct));
         if (rdSent)
         begin
            rdLog.push_back(int'(rdAddr));
            pendAddr.push_back(rdAddr);
            pendDelay.push_back(int'(nextRand() % 32'd8) + 1);
            if (rdAddr == numLines[addrWidth-1:0] && missLeft > 0)
            begin
               pendData.push_back('0);   // flag word not set yet
               missLeft--;
            end
            else
               pendData.push_back(rdMem[rdAddr[3:0]]);
         end
      end
   end

   // ******************************
   // checks and test helpers
   // ******************************
   string curTest;
   int    errors = 0;
   int    testErrs;
   int    testsRun = 0;
   int    refWr[$];   // logs of the unstalled csr run
   int    refRd[$];

   task automatic check(input string what, input logic [lineWidth-1:0] expVal,
                        input logic [lineWidth-1:0] actVal);
      if (expVal !== actVal)
      begin
         $display("ERR %s %s: expected %0h, actual %0h", curTest, what, expVal, actVal);
         errors++;
         testErrs++;
      end
   endtask

   // sel 0 waits for the flag write, sel 1 for testCmp
   task automatic waitHigh(input int sel, input int limit);
      int n = 0;
      while (((sel == 0) ? !flagSeen : !testCmp) && n < limit)
      begin
         @(negedge Clk_400);
         n++;
      end
      if ((sel == 0) ? !flagSeen : !testCmp)
      begin
         $display("%s: timed out waiting for %s", curTest,
                  (sel == 0) ? "the flag write" : "testCmp");
         errors++;
         testErrs++;
      end
   endtask

   // reset, set up the host, pulse go, answer by csr if asked, wait for the end
   task automatic runExchange(input string name, input logic [cfgWidth-1:0] cfg,
                              input int n, input int pct, input int misses,
                              input int corrupt);
      curTest     = name;
      testErrs    = 0;
      rstN        = 1'b0;
      testCfg     = cfg;
      numLines    = numLinesWidth'(n);
      sentPct     = pct;
      missLeft    = misses;
      corruptAddr = corrupt;
      repeat (16) @(negedge Clk_400);
      rstN = 1'b1;
      @(negedge Clk_400);
      go = 1'b1;
      @(negedge Clk_400);
      go = 1'b0;
      if (cfg[cfgModeMsb:cfgModeLsb] != pollMode)
      begin
         waitHigh(0, 2000);
         csrWrite = 1'b1;   // host answer
         @(negedge Clk_400);
         csrWrite = 1'b0;
      end
      waitHigh(1, 5000);
   endtask

   task automatic endTest();
      testsRun++;
      if (testErrs == 0)
         $display("%s: passed", curTest);
      else
         $display("%s: %0d error(s)", curTest, testErrs);
   endtask

   // lines 0..N-1 carry their address in the low 17 bits, fence, flag at N
   task automatic checkWrites(input int n);
      int total;
      total = (n == 0) ? 1 : n + 2;
      check("write count", total, wrLog.size());
      for (int a = 0; a < n && a < wrLog.size(); a++)
      begin
         check("write addr", a, wrLog[a]);
         check("line data", {fillLine[lineWidth-1:17], 17'(a)}, wrMem[a]);
      end
      if (wrLog.size() == total)
      begin
         if (n > 0)
            check("fence", -1, wrLog[n]);
         check("flag addr", n, wrLog[total-1]);
         check("flag data", flagLine, wrMem[n]);
      end
   endtask

   // ******************************
   // directed tests
   // ******************************
   task automatic csrSixLines();
      runExchange("csr 6 lines", 8'h40, 6, 100, 0, -1);
      checkWrites(6);
      check("read count", 6, rdLog.size());
      foreach (rdLog[i])
         check("read addr", i, rdLog[i]);
      check("testCmp", 1, testCmp);
      check("errorValid", 0, errorValid);
      refWr = wrLog;
      refRd = rdLog;
      endTest();
   endtask

   task automatic pollFourLines();
      runExchange("poll 4 lines", 8'h00, 4, 100, 3, -1);
      checkWrites(4);
      check("read count", 8, rdLog.size());   // 4 polls, then 4 bulk
      foreach (rdLog[i])
         check("read addr", (i < 4) ? 4 : i - 4, rdLog[i]);
      check("testCmp", 1, testCmp);
      check("errorValid", 0, errorValid);
      endTest();
   endtask

   task automatic zeroLines();
      runExchange("csr 0 lines", 8'h40, 0, 100, 0, -1);
      checkWrites(0);
      check("read count", 0, rdLog.size());
      check("testCmp", 1, testCmp);
      endTest();
      runExchange("poll 0 lines", 8'h00, 0, 100, 0, -1);
      checkWrites(0);
      check("read count", 1, rdLog.size());   // one poll of address 0
      foreach (rdLog[i])
         check("read addr", 0, rdLog[i]);
      check("testCmp", 1, testCmp);
      endTest();
   endtask

   task automatic dataError();
      runExchange("data error", 8'h40, 6, 100, 0, 2);
      check("errorValid", 1, errorValid);
      // line 2 low bits 0x0002, spoiled by xor 0xff
      check("errorInfo", {32'(corruptPos), 32'd2, 32'(16'd2 ^ 16'h00ff)}, errorInfo);
      repeat (4) @(negedge Clk_400);
      check("errorValid held", 1, errorValid);
      check("testCmp", 1, testCmp);
      endTest();
   endtask

   task automatic backPressure();
      runExchange("back-pressure", 8'h40, 6, 20, 0, -1);
      check("write count", refWr.size(), wrLog.size());
      foreach (refWr[i])
         check("write order", refWr[i], (i < wrLog.size()) ? wrLog[i] : -2);
      check("read count", refRd.size(), rdLog.size());
      foreach (refRd[i])
         check("read order", refRd[i], (i < rdLog.size()) ? rdLog[i] : -2);
      check("testCmp", 1, testCmp);
      check("errorValid", 0, errorValid);
      endTest();
   endtask

   initial
   begin
      @(negedge Clk_400);
      csrSixLines();
      pollFourLines();
      zeroLines();
      dataError();
      backPressure();
      errors += i_dut.uAssertions.failCount;   // bound handshake checks
      $display("%0d tests, %0d errors", testsRun, errors);
      if (errors == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

endmodule

// File: test/pingPongAssertions.sv
// concurrent checks bound into swPingPongTop
// requests hold until their sent strobe, no write and fence together,
// testCmp stays high once set

module pingPongAssertions
   import pingPongPkg::*;
(
   input logic                 Clk_400,
   input logic                 rstN,
   input logic [addrWidth-1:0] wrAddr,
   input logic [lineWidth-1:0] wrData,
   input logic                 wrEn,
   input logic                 wrFence,
   input logic                 wrSent,
   input logic [addrWidth-1:0] rdAddr,
   input logic                 rdEn,
   input logic                 rdSent,
   input logic                 testCmp
);

   int failCount = 0;   // summed into the testbench summary

   wrHold: assert property (@(posedge Clk_400) disable iff (!rstN)
      (wrEn || wrFence) && !wrSent |=> $stable({wrEn, wrFence, wrAddr, wrData}))
   else
   begin
      failCount++;
      $error("write request changed before wrSent");
   end

   rdHold: assert property (@(posedge Clk_400) disable iff (!rstN)
      rdEn && !rdSent |=> rdEn && $stable(rdAddr))
   else
   begin
      failCount++;
      $error("read request changed before rdSent");
   end

   // one request kind at a time
   wrOneKind: assert property (@(posedge Clk_400) disable iff (!rstN)
      !(wrEn && wrFence))
   else
   begin
      failCount++;
      $error("wrEn and wrFence high together");
   end

   cmpSticky: assert property (@(posedge Clk_400) disable iff (!rstN)
      testCmp |=> testCmp)
   else
   begin
      failCount++;
      $error("testCmp dropped before reset");
   end

endmodule

bind swPingPongTop pingPongAssertions uAssertions (.*);

// File: hdl/swPingPongTop.sv
// top of the ping-pong latency engine
// lineWriter runs the write phase, readEngine the notification and
// read-back, rspChecker the data check on the returned lines
// requests use a hold-until-sent handshake, responses have no back-pressure

module swPingPongTop
   import pingPongPkg::*;
(
   input  logic                      Clk_400,
   input  logic                      rstN,
   // ******************************
   // control
   // ******************************
   input  logic                      go,
   input  logic [numLinesWidth-1:0]  numLines,
   input  logic [cfgWidth-1:0]       testCfg,    // [7:6] notify mode
   input  logic                      csrWrite,
   // write request
   output logic [addrWidth-1:0]      wrAddr,
   output logic [lineWidth-1:0]      wrData,
   output logic                      wrEn,
   output logic                      wrFence,
   input  logic                      wrSent,
   // read request
   output logic [addrWidth-1:0]      rdAddr,
   output logic                      rdEn,
   input  logic                      rdSent,
   // read response
   input  logic                      rdRspValid,
   input  logic [addrWidth-1:0]      rdRspAddr,
   input  logic [lineWidth-1:0]      rdData,
   // status
   output logic                      testCmp,
   output logic                      errorValid,
   output logic [errorInfoWidth-1:0] errorInfo
);

   logic writeDone;    // writer -> read engine
   logic rspCheckEn;   // read engine -> checker

   lineWriter uWriter (
      .Clk_400   (Clk_400),
      .rstN      (rstN),
      .go        (go),
      .numLines  (numLines),
      .wrSent    (wrSent),
      .wrAddr    (wrAddr),
      .wrData    (wrData),
      .wrEn      (wrEn),
      .wrFence   (wrFence),
      .writeDone (writeDone)
   );

   readEngine uReader (
      .Clk_400    (Clk_400),
      .rstN       (rstN),
      .testCfg    (testCfg),
      .numLines   (numLines),
      .csrWrite   (csrWrite),
      .writeDone  (writeDone),
      .rdSent     (rdSent),
      .rdRspValid (rdRspValid),
      .rdData     (rdData),
      .rdAddr     (rdAddr),
      .rdEn       (rdEn),
      .rspCheckEn (rspCheckEn),
      .testCmp    (testCmp)
   );

   rspChecker uChecker (
      .Clk_400    (Clk_400),
      .rstN       (rstN),
      .rdRspValid (rdRspValid),
      .rdRspAddr  (rdRspAddr),
      .rdData     (rdData),
      .rspCheckEn (rspCheckEn),
      .errorValid (errorValid),
      .errorInfo  (errorInfo)
   );

endmodule

// File: hdl/rspChecker.sv
// checks bulk read responses against their own address
// low data bits must match the low address bits
// one register stage before the compare
// errorValid is sticky until reset
// errorInfo holds {count, addr, data} of the latest bad response

module rspChecker
   import pingPongPkg::*;
(
   input  logic                      Clk_400,
   input  logic                      rstN,
   input  logic                      rdRspValid,
   input  logic [addrWidth-1:0]      rdRspAddr,
   input  logic [lineWidth-1:0]      rdData,
   input  logic                      rspCheckEn,   // only bulk responses
   output logic                      errorValid,
   output logic [errorInfoWidth-1:0] errorInfo
);

   logic                  rspValidQ;
   logic [addrWidth-1:0]  addrQ;      // full line address for errorInfo
   logic [checkWidth-1:0] dataQ;
   logic [countWidth-1:0] rspCount;   // checked responses so far
   logic                  badRsp;

   assign badRsp = rspValidQ && (dataQ != addrQ[checkWidth-1:0]);

   always_ff @(posedge Clk_400 or negedge rstN)
   begin
      if (!rstN)
      begin
         rspValidQ  <= 1'b0;
         rspCount   <= '0;
         errorValid <= 1'b0;
      end
      else
      begin
         rspValidQ <= rdRspValid && rspCheckEn;
         if (rdRspValid && rspCheckEn)
            rspCount <= rspCount + 1'b1;
         if (badRsp)
            errorValid <= 1'b1;   // stays set
      end
   end

   // response payload and error capture
   always_ff @(posedge Clk_400)
   begin
      addrQ <= rdRspAddr;
      dataQ <= rdData[checkWidth-1:0];
      if (badRsp)
         errorInfo <= {infoFieldWidth'(rspCount), infoFieldWidth'(addrQ),
                       infoFieldWidth'(dataQ)};
   end

endmodule

// File: hdl/readEngine.sv
// read side of the ping-pong test
// waits for the host answer (poll of the flag line or a csr strobe),
// then reads the N lines back and counts the responses
// poll and bulk reads share one read request port
// testCmp rises once both phases are done and holds until reset

module readEngine
   import pingPongPkg::*;
(
   input  logic                     Clk_400,
   input  logic                     rstN,
   input  logic [cfgWidth-1:0]      testCfg,
   input  logic [numLinesWidth-1:0] numLines,
   input  logic                     csrWrite,     // host answer in csr mode
   input  logic                     writeDone,    // from lineWriter
   input  logic                     rdSent,
   input  logic                     rdRspValid,
   input  logic [lineWidth-1:0]     rdData,
   output logic [addrWidth-1:0]     rdAddr,
   output logic                     rdEn,
   output logic                     rspCheckEn,   // bulk read window
   output logic                     testCmp
);

   notifyMode             cfgMode;
   logic                  pollSel;
   logic                  csrSel;
   logic                  flagHit;
   logic                  startRd;    // one-cycle start of the bulk read
   pollState              pollSt;
   rdState                rdSt;
   logic [addrWidth-1:0]  bulkAddr;
   logic [countWidth-1:0] reqCount;   // 1-based, like the writer
   logic [countWidth-1:0] rspCount;

   assign cfgMode = notifyMode'(testCfg[cfgModeMsb:cfgModeLsb]);
   assign pollSel = (cfgMode == pollMode);
   assign csrSel  = (cfgMode == csrMode) || testCfg[cfgModeMsb];   // 2, 3 act as csr

   assign flagHit = (rdData[flagWordMsb:flagWordLsb] == '1);

   // answer seen: good poll response or csr strobe while idle
   assign startRd = ((pollSt == psWait) && rdRspValid && flagHit)
                 || (csrSel && csrWrite && (rdSt == rsIdle));

   // shared read port, poll always targets the flag line
   assign rdEn   = (pollSt == psRead) || (rdSt == rsRead);
   assign rdAddr = (rdSt == rsRead) ? bulkAddr : numLines[addrWidth-1:0];

   assign rspCheckEn = (rdSt == rsRead) || (rdSt == rsCollect);

   // ******************************
   // poll FSM
   // ******************************
   always_ff @(posedge Clk_400 or negedge rstN)
   begin
      if (!rstN)
         pollSt <= psIdle;
      else
      begin
         case (pollSt)
            psIdle:
               if (pollSel && writeDone)
                  pollSt <= psRead;
            psRead:
               if (rdSent)
                  pollSt <= psWait;
            psWait:
            begin
               if (rdRspValid)
                  pollSt <= flagHit ? psDone : psRead;   // miss: poll again
            end
            default:
               pollSt <= pollSt;
         endcase
      end
   end

   // ******************************
   // bulk read FSM
   // ******************************
   always_ff @(posedge Clk_400 or negedge rstN)
   begin
      if (!rstN)
      begin
         rdSt     <= rsIdle;
         bulkAddr <= '0;
         reqCount <= '0;
         rspCount <= '0;
      end
      else
      begin
         if (rdRspValid && rspCheckEn)
            rspCount <= rspCount + 1'b1;   // any order, any latency
         case (rdSt)
            rsIdle:
            begin
               bulkAddr <= '0;
               reqCount <= countWidth'(1);
               rspCount <= '0;
               if (startRd)
                  rdSt <= (numLines != '0) ? rsRead : rsDone;   // N=0 done at once
            end
            rsRead:
            begin
               if (rdSent)
               begin
                  bulkAddr <= bulkAddr + 1'b1;
                  reqCount <= reqCount + 1'b1;
                  if (numLinesWidth'(reqCount) == numLines)
                     rdSt <= rsCollect;
               end
            end
            rsCollect:
            begin
               if (numLinesWidth'(rspCount) == numLines)
                  rdSt <= rsDone;
            end
            default:
               rdSt <= rdSt;
         endcase
      end
   end

   // completion, sticky
   always_ff @(posedge Clk_400 or negedge rstN)
   begin
      if (!rstN)
         testCmp <= 1'b0;
      else if (writeDone && (rdSt == rsDone))
         testCmp <= 1'b1;
   end

endmodule

// File: hdl/lineWriter.sv
// write phase of the ping-pong test
// after go: N bulk lines, one write fence, then the flag line at address N
// a request is held until wrSent accepts it
// writeDone goes high once the flag write has been accepted

module lineWriter
   import pingPongPkg::*;
(
   input  logic                     Clk_400,
   input  logic                     rstN,
   input  logic                     go,         // start pulse, seen in idle
   input  logic [numLinesWidth-1:0] numLines,   // N
   input  logic                     wrSent,     // current request taken
   output logic [addrWidth-1:0]     wrAddr,
   output logic [lineWidth-1:0]     wrData,
   output logic                     wrEn,
   output logic                     wrFence,
   output logic                     writeDone
);

   wrState                state;
   logic [countWidth-1:0] wrCount;   // 1-based index of the line on the bus
   logic                  lastLine;

   assign lastLine = (numLinesWidth'(wrCount) == numLines);

   // requests decode straight from state, so they hold until accepted
   assign wrEn      = (state == wsWrite) || (state == wsFlag);
   assign wrFence   = (state == wsFence);
   assign writeDone = (state == wsDone);

   // flag line goes out whole, bulk lines carry their address
   assign wrData = (state == wsFlag) ? flagLine
                 : {fillLine[lineWidth-1:fillAddrBits], wrAddr[fillAddrBits-1:0]};

   // ******************************
   // write FSM
   // ******************************
   always_ff @(posedge Clk_400 or negedge rstN)
   begin
      if (!rstN)
      begin
         state   <= wsIdle;
         wrAddr  <= '0;
         wrCount <= '0;
      end
      else
      begin
         case (state)
            wsIdle:
            begin
               wrAddr  <= '0;
               wrCount <= countWidth'(1);
               if (go)
               begin
                  if (numLines != '0)
                     state <= wsWrite;
                  else
                     state <= wsFlag;   // N=0: flag at address 0, no fence
               end
            end
            wsWrite:
            begin
               if (wrSent)
               begin
                  wrAddr  <= wrAddr + 1'b1;   // ends at N for the flag
                  wrCount <= wrCount + 1'b1;
                  if (lastLine)
                     state <= wsFence;
               end
            end
            wsFence:
            begin
               if (wrSent)
                  state <= wsFlag;
            end
            wsFlag:
            begin
               if (wrSent)
                  state <= wsDone;
            end
            default:
               state <= state;   // done until reset
         endcase
      end
   end

endmodule

// File: hdl/pingPongPkg.sv
// shared widths, line patterns, mode codes and FSM encodings
// for the host/FPGA ping-pong latency engine
// imported by every RTL module and by the testbench

package pingPongPkg;

   // ******************************
   // widths
   // ******************************
   localparam int addrWidth      = 20;   // cache-line address
   localparam int lineWidth      = 512;  // one cache line
   localparam int numLinesWidth  = 32;   // line-count input
   localparam int countWidth     = 21;   // req / rsp counters
   localparam int checkWidth     = 16;   // low bits compared by the checker
   localparam int infoFieldWidth = 32;   // one field of errorInfo
   localparam int errorInfoWidth = 96;   // {count, addr, data}
   localparam int cfgWidth       = 8;    // testCfg register
   localparam int cfgModeMsb     = 7;    // mode select field
   localparam int cfgModeLsb     = 6;

   // ******************************
   // line patterns
   // ******************************
   localparam logic [lineWidth-1:0] fillLine = {16{32'h0000_0001}};  // bulk line body
   localparam int                   fillAddrBits = 17;  // address stamped into fillLine
   localparam logic [lineWidth-1:0] flagLine = {{14{32'h0000_0000}}, {64{1'b1}}};
   localparam int                   flagWordMsb = 63;   // word polled for the answer
   localparam int                   flagWordLsb = 32;

   // notification mode, codes 2 and 3 fall back to csr
   typedef enum logic [1:0] {
      pollMode = 2'd0,
      csrMode  = 2'd1
   } notifyMode;

   // writer states
   typedef enum logic [2:0] {wsIdle, wsWrite, wsFence, wsFlag, wsDone} wrState;
   // bulk read states
   typedef enum logic [1:0] {rsIdle, rsRead, rsCollect, rsDone} rdState;
   // poll states
   typedef enum logic [1:0] {psIdle, psRead, psWait, psDone} pollState;

endpackage
